//--- logic/iosys_pkg.sv
// address map, sizes, shared types and flash reader states of the io subsystem
`default_nettype none

package iosys_pkg;

    typedef logic [31:0] word_t;      // cpu bus data
    typedef logic [22:0] ram_addr_t;  // 8 MB main memory
    typedef logic [3:0]  strb_t;      // byte lane write strobe
    typedef logic [7:0]  byte_t;
    typedef logic [11:0] joy_t;       // R L X A RT LT DN UP START SELECT Y B

    // spi flash read sequence
    typedef enum logic [1:0] {
        idle,
        cmd,
        data,
        done
    } flash_state_t;

    // firmware image location and size
    localparam logic [23:0] flash_base     = 24'h50_0000;
    localparam byte_t       flash_read_cmd = 8'h03;   // plain read, no dummy cycles
    localparam int          fw_len         = 256;     // bytes

    // 21.477 MHz system clock
    localparam int ticks_per_ms = 21477;

    localparam logic [15:0] core_id = 16'd2;

    // register map
    localparam word_t reg_char_addr   = 32'h0200_0000;  // text display, overlay bit only
    localparam word_t reg_romctl_addr = 32'h0200_0030;  // 1 starts rom load, 0 ends it
    localparam word_t reg_romdat_addr = 32'h0200_0034;  // 4 bytes per write
    localparam word_t reg_joy_addr    = 32'h0200_0040;
    localparam word_t reg_time_addr   = 32'h0200_0050;  // ms since reset
    localparam word_t reg_id_addr     = 32'h0200_0060;

endpackage

`default_nettype wire

//--- logic/spi_flash_reader.sv
// spi flash master that issues one read command and streams the firmware bytes out
`timescale 1ns/100ps
`default_nettype none

module spi_flash_reader (
    input  wire                       clk,
    input  wire                       resetn,
    input  wire                       start,
    output iosys_pkg::byte_t          dout,
    output logic                      dout_strb,
    output logic                      flash_cs_n,
    output logic                      flash_sck,
    output logic                      flash_mosi,
    input  wire                       flash_miso
);

    iosys_pkg::flash_state_t state;
    logic [31:0]             out_sr;    // read command then address, msb first
    iosys_pkg::byte_t        in_sr;
    logic [4:0]              bit_cnt;   // counts falling sck edges
    logic [$clog2(iosys_pkg::fw_len)-1:0] byte_cnt;

    assign flash_mosi = out_sr[31];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= iosys_pkg::idle;
            flash_cs_n <= 1'b1;
            flash_sck  <= 1'b0;
            out_sr     <= '0;
            bit_cnt    <= '0;
            byte_cnt   <= '0;
            dout_strb  <= 1'b0;
        end else begin
            dout_strb <= 1'b0;
            case (state)
                iosys_pkg::idle: begin
                    if (start) begin
                        state      <= iosys_pkg::cmd;
                        flash_cs_n <= 1'b0;
                        out_sr     <= {iosys_pkg::flash_read_cmd, iosys_pkg::flash_base};
                        bit_cnt    <= '0;
                    end
                end
                iosys_pkg::cmd: begin
                    flash_sck <= ~flash_sck;
                    if (flash_sck) begin                   // falling edge
                        out_sr  <= {out_sr[30:0], 1'b0};
                        bit_cnt <= bit_cnt + 5'd1;     // wraps to 0 for the data phase
                        if (bit_cnt == 5'd31) begin
                            state    <= iosys_pkg::data;
                            byte_cnt <= '0;
                        end
                    end
                end
                iosys_pkg::data: begin
                    flash_sck <= ~flash_sck;
                    if (!flash_sck) begin
                        // rising edge samples miso, 8th bit completes a byte
                        if (bit_cnt[2:0] == 3'd7)
                            dout_strb <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 5'd1;
                        if (bit_cnt[2:0] == 3'd7) begin
                            byte_cnt <= byte_cnt + 1'b1;
                            if (int'(byte_cnt) == iosys_pkg::fw_len - 1) begin
                                state      <= iosys_pkg::done;
                                flash_cs_n <= 1'b1;
                            end
                        end
                    end
                end
                default: ;  // done until next reset
            endcase
        end
    end

    // shift in, msb first
    always_ff @(posedge clk) begin
        if (state == iosys_pkg::data && !flash_sck) begin
            in_sr <= {in_sr[6:0], flash_miso};
            if (bit_cnt[2:0] == 3'd7)
                dout <= {in_sr[6:0], flash_miso};
        end
    end

    a_strb_in_data: assert property (@(posedge clk) disable iff (!resetn)
        dout_strb |-> state == iosys_pkg::data);

endmodule

`default_nettype wire

//--- logic/firmware_loader.sv
// firmware copy from spi flash into main memory, holds the cpu until done
`timescale 1ns/100ps
`default_nettype none

module firmware_loader (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        ram_busy,
    input  wire iosys_pkg::byte_t      flash_byte,
    input  wire                        flash_strb,
    output logic                       flash_start,
    output logic                       loading,
    output logic                       loaded,
    output logic                       wr,
    output iosys_pkg::ram_addr_t       addr,
    output iosys_pkg::word_t           wdata,
    output iosys_pkg::strb_t           wstrb
);

    logic                 started;
    iosys_pkg::ram_addr_t next_addr;   // address of the next flash byte

    // kick the reader once sdram is up
    assign flash_start = !started && !ram_busy;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            started   <= 1'b0;
            loading   <= 1'b0;
            loaded    <= 1'b0;
            wr        <= 1'b0;
            next_addr <= '0;
        end else begin
            wr <= flash_strb && loading;   // one cycle write pulse
            if (flash_start) begin
                started <= 1'b1;
                loading <= 1'b1;
            end
            if (flash_strb && loading)
                next_addr <= next_addr + 1'b1;
            if (wr && addr == iosys_pkg::ram_addr_t'(iosys_pkg::fw_len - 1)) begin
                loading <= 1'b0;
                loaded  <= 1'b1;
            end
        end
    end

    // byte replicated on all lanes, strobe picks the lane
    always_ff @(posedge clk) begin
        if (flash_strb) begin
            addr  <= next_addr;
            wdata <= {4{flash_byte}};
            wstrb <= iosys_pkg::strb_t'(1) << next_addr[1:0];
        end
    end

    a_loaded_sticky: assert property (@(posedge clk) disable iff (!resetn)
        loaded |=> loaded);

    // every write lands while the loader owns the memory port
    a_wr_in_loading: assert property (@(posedge clk) disable iff (!resetn)
        wr |-> loading && !loaded);

endmodule

`default_nettype wire

//--- logic/io_regs.sv
// cpu address decode, register read mux, overlay, rom control and millisecond timer
`timescale 1ns/100ps
`default_nettype none

module io_regs (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      cpu_valid,
    input  wire iosys_pkg::word_t    cpu_addr,
    input  wire iosys_pkg::word_t    cpu_wdata,
    input  wire iosys_pkg::strb_t    cpu_wstrb,
    input  wire iosys_pkg::joy_t     joy1,
    input  wire iosys_pkg::joy_t     joy2,
    output logic                     ram_sel,
    output logic                     reg_ready,
    output iosys_pkg::word_t         reg_rdata,
    output logic                     overlay,
    output logic                     rom_loading,
    output logic                     romdat_we
);

    logic char_sel;
    logic romctl_sel;
    logic romdat_sel;
    logic joy_sel;
    logic time_sel;
    logic id_sel;

    logic [$clog2(iosys_pkg::ticks_per_ms)-1:0] tick_cnt;
    iosys_pkg::word_t time_ms;   // wraps after about 49 days

    assign ram_sel    = cpu_valid && cpu_addr[31:23] == '0;   // low 8 MB
    assign char_sel   = cpu_valid && cpu_addr == iosys_pkg::reg_char_addr;
    assign romctl_sel = cpu_valid && cpu_addr == iosys_pkg::reg_romctl_addr;
    assign romdat_sel = cpu_valid && cpu_addr == iosys_pkg::reg_romdat_addr;
    assign joy_sel    = cpu_valid && cpu_addr == iosys_pkg::reg_joy_addr;
    assign time_sel   = cpu_valid && cpu_addr == iosys_pkg::reg_time_addr;
    assign id_sel     = cpu_valid && cpu_addr == iosys_pkg::reg_id_addr;

    // registers and unmapped space answer in the same cycle
    assign reg_ready = cpu_valid && !ram_sel;

    assign romdat_we = romdat_sel && |cpu_wstrb;

    always_comb begin
        reg_rdata = '0;   // unmapped and write-only registers
        if (joy_sel)
            reg_rdata = {4'b0, joy2, 4'b0, joy1};
        else if (time_sel)
            reg_rdata = time_ms;
        else if (id_sel)
            reg_rdata = {16'b0, iosys_pkg::core_id};
    end

    // menu overlay is on out of reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            overlay <= 1'b1;
        end else if (char_sel && cpu_wstrb[0]) begin
            case (cpu_wdata[25:24])
                2'd1: overlay <= 1'b1;
                2'd2: overlay <= 1'b0;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rom_loading <= 1'b0;
        end else if (romctl_sel && |cpu_wstrb) begin
            if (cpu_wdata[7:0] == 8'd1)
                rom_loading <= 1'b1;
            else if (cpu_wdata[7:0] == 8'd0)
                rom_loading <= 1'b0;
        end
    end

    // millisecond timer
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tick_cnt <= '0;
            time_ms  <= '0;
        end else if (int'(tick_cnt) == iosys_pkg::ticks_per_ms - 1) begin
            tick_cnt <= '0;
            time_ms  <= time_ms + 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    a_ready_excl: assert property (@(posedge clk) disable iff (!resetn)
        !(reg_ready && ram_sel));

endmodule

`default_nettype wire

//--- logic/rom_byte_streamer.sv
// rom data register output with four byte strobes per written word
`timescale 1ns/100ps
`default_nettype none

module rom_byte_streamer (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      we,
    input  wire iosys_pkg::word_t    wdata,
    output iosys_pkg::byte_t         rom_do,
    output logic                     rom_do_valid
);

    logic [3:0]       cnt;    // 16 cycles per word and 0 when idle
    iosys_pkg::word_t sbuf;   // current byte in the low lane

    assign rom_do = sbuf[7:0];

    // 2 cycles on then 2 off
    assign rom_do_valid = cnt[1];

    always_ff @(posedge clk) begin
        if (!resetn)
            cnt <= '0;
        else if (we)
            cnt <= 4'd15;          // restart on every write
        else if (cnt != 4'd0)
            cnt <= cnt - 4'd1;
    end

    always_ff @(posedge clk) begin
        if (we)
            sbuf <= wdata;
        else if (cnt[1:0] == 2'd0 && cnt != 4'd0)
            sbuf <= {8'h00, sbuf[31:8]};   // next byte with lsb first
    end

endmodule

`default_nettype wire

//--- logic/iosys.sv
// io subsystem top: firmware loader, register block, rom streamer and memory port mux
`timescale 1ns/100ps
`default_nettype none

module iosys (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        ram_busy,
    input  wire                        cpu_valid,
    input  wire iosys_pkg::word_t      cpu_addr,
    input  wire iosys_pkg::word_t      cpu_wdata,
    input  wire iosys_pkg::strb_t      cpu_wstrb,
    output logic                       cpu_ready,
    output iosys_pkg::word_t           cpu_rdata,
    output logic                       cpu_resetn,
    output logic                       ram_valid,
    output iosys_pkg::ram_addr_t       ram_addr,
    output iosys_pkg::word_t           ram_wdata,
    output iosys_pkg::strb_t           ram_wstrb,
    input  wire                        ram_ready,
    input  wire iosys_pkg::word_t      ram_rdata,
    input  wire iosys_pkg::joy_t       joy1,
    input  wire iosys_pkg::joy_t       joy2,
    output logic                       overlay,
    output logic                       rom_loading,
    output iosys_pkg::byte_t           rom_do,
    output logic                       rom_do_valid,
    output logic                       flash_cs_n,
    output logic                       flash_sck,
    output logic                       flash_mosi,
    input  wire                        flash_miso
);

    logic                 flash_start;
    iosys_pkg::byte_t     flash_byte;
    logic                 flash_strb;

    logic                 ld_loading;
    logic                 ld_loaded;
    logic                 ld_wr;
    iosys_pkg::ram_addr_t ld_addr;
    iosys_pkg::word_t     ld_wdata;
    iosys_pkg::strb_t     ld_wstrb;

    logic                 ram_sel;
    logic                 reg_ready;
    iosys_pkg::word_t     reg_rdata;
    logic                 romdat_we;

    spi_flash_reader flash_i (
        .clk        (clk),
        .resetn     (resetn),
        .start      (flash_start),
        .dout       (flash_byte),
        .dout_strb  (flash_strb),
        .flash_cs_n (flash_cs_n),
        .flash_sck  (flash_sck),
        .flash_mosi (flash_mosi),
        .flash_miso (flash_miso)
    );

    firmware_loader loader_i (
        .clk         (clk),
        .resetn      (resetn),
        .ram_busy    (ram_busy),
        .flash_byte  (flash_byte),
        .flash_strb  (flash_strb),
        .flash_start (flash_start),
        .loading     (ld_loading),
        .loaded      (ld_loaded),
        .wr          (ld_wr),
        .addr        (ld_addr),
        .wdata       (ld_wdata),
        .wstrb       (ld_wstrb)
    );

    io_regs regs_i (
        .clk         (clk),
        .resetn      (resetn),
        .cpu_valid   (cpu_valid),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_wstrb   (cpu_wstrb),
        .joy1        (joy1),
        .joy2        (joy2),
        .ram_sel     (ram_sel),
        .reg_ready   (reg_ready),
        .reg_rdata   (reg_rdata),
        .overlay     (overlay),
        .rom_loading (rom_loading),
        .romdat_we   (romdat_we)
    );

    rom_byte_streamer rom_i (
        .clk          (clk),
        .resetn       (resetn),
        .we           (romdat_we),
        .wdata        (cpu_wdata),
        .rom_do       (rom_do),
        .rom_do_valid (rom_do_valid)
    );

    // cpu runs only after the firmware copy
    assign cpu_resetn = resetn && ld_loaded;

    // loader owns the memory port while copying
    assign ram_valid = ld_loading ? ld_wr    : ram_sel;
    assign ram_addr  = ld_loading ? ld_addr  : cpu_addr[22:0];
    assign ram_wdata = ld_loading ? ld_wdata : cpu_wdata;
    assign ram_wstrb = ld_loading ? ld_wstrb : cpu_wstrb;

    assign cpu_ready = (ram_sel && ram_ready) || reg_ready;
    assign cpu_rdata = ram_sel ? ram_rdata : reg_rdata;

    // a cpu held in reset leaves its bus idle
    a_bus_idle: assert property (@(posedge clk) disable iff (!resetn)
        !cpu_resetn |-> !cpu_valid);

endmodule

`default_nettype wire

//--- sim/clock_gen.sv
// testbench clock and reset source, 4 ns period, reset low for 5 cycles
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/flash_model.sv
// spi flash model that answers read command 0x03 with a byte pattern computed from the address
`timescale 1ns/100ps
`default_nettype none

module flash_model (
    input  wire  cs_n,
    input  wire  sck,
    input  wire  mosi,
    output logic miso
);

    logic [31:0] cmd_sr;    // command byte then 24 bit address
    int          bit_n = 0; // rising sck edges since chip select
    int          pos;
    logic [23:0] rd_addr;
    logic [7:0]  cur;

    // fill rule where every address bit takes part
    function automatic logic [7:0] byte_at(input logic [23:0] a);
        return (a[7:0] ^ a[23:16]) + {a[12:8], a[15:13]} + 8'h3c;
    endfunction

    initial miso = 1'b0;

    // mode 0 so mosi is sampled on the rising edge
    always @(posedge sck or posedge cs_n) begin
        if (cs_n) begin
            bit_n = 0;
        end else begin
            if (bit_n < 32)
                cmd_sr = {cmd_sr[30:0], mosi};
            bit_n = bit_n + 1;
        end
    end

    // data changes on the falling edge msb first
    always @(negedge sck) begin
        if (!cs_n && bit_n >= 32) begin
            pos     = bit_n - 32;
            rd_addr = cmd_sr[23:0] + 24'(pos / 8);
            cur     = byte_at(rd_addr);
            if (cmd_sr[31:24] == 8'h03)
                miso <= cur[7 - pos % 8];
            else
                miso <= 1'b1;   // bus floats high on an unknown command
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_iosys.sv
// io subsystem testbench with bus driver, ram responder, assertions and reporting
`timescale 1ns/100ps
`default_nettype none

module tb_iosys;

    localparam iosys_pkg::word_t unmapped_addr = 32'h0200_0070;
    // about 4.2k load cycles and 64.4k timer cycles plus margin
    localparam int cycle_limit = 70_000;

    logic                 clk;
    logic                 resetn;
    logic                 ram_busy;
    logic                 cpu_valid;
    iosys_pkg::word_t     cpu_addr;
    iosys_pkg::word_t     cpu_wdata;
    iosys_pkg::strb_t     cpu_wstrb;
    logic                 cpu_ready;
    iosys_pkg::word_t     cpu_rdata;
    logic                 cpu_resetn;
    logic                 ram_valid;
    iosys_pkg::ram_addr_t ram_addr;
    iosys_pkg::word_t     ram_wdata;
    iosys_pkg::strb_t     ram_wstrb;
    logic                 ram_ready = 1'b0;
    iosys_pkg::word_t     ram_rdata = '0;
    iosys_pkg::joy_t      joy1;
    iosys_pkg::joy_t      joy2;
    logic                 overlay;
    logic                 rom_loading;
    iosys_pkg::byte_t     rom_do;
    logic                 rom_do_valid;
    logic                 flash_cs_n;
    logic                 flash_sck;
    logic                 flash_mosi;
    logic                 flash_miso;

    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycles = 0;
    int load_cnt;                 // loader writes seen so far
    int rom_k;                    // edges since the last rom data write or 0 before any
    iosys_pkg::word_t rom_word;
    logic overlay_exp;
    iosys_pkg::word_t ram_chk_addr = '1;
    iosys_pkg::word_t ram_chk_word;
    logic rom_wr_seen;

    iosys_pkg::word_t mem [int unsigned];   // word address to data
    int               delay_left = -1;
    logic             ready_next = 1'b0;
    iosys_pkg::word_t rdata_next = '0;

    clock_gen clk_i (
        .clk    (clk),
        .resetn (resetn)
    );

    flash_model flash_i (
        .cs_n (flash_cs_n),
        .sck  (flash_sck),
        .mosi (flash_mosi),
        .miso (flash_miso)
    );

    iosys dut_i (
        .clk          (clk),
        .resetn       (resetn),
        .ram_busy     (ram_busy),
        .cpu_valid    (cpu_valid),
        .cpu_addr     (cpu_addr),
        .cpu_wdata    (cpu_wdata),
        .cpu_wstrb    (cpu_wstrb),
        .cpu_ready    (cpu_ready),
        .cpu_rdata    (cpu_rdata),
        .cpu_resetn   (cpu_resetn),
        .ram_valid    (ram_valid),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_wstrb    (ram_wstrb),
        .ram_ready    (ram_ready),
        .ram_rdata    (ram_rdata),
        .joy1         (joy1),
        .joy2         (joy2),
        .overlay      (overlay),
        .rom_loading  (rom_loading),
        .rom_do       (rom_do),
        .rom_do_valid (rom_do_valid),
        .flash_cs_n   (flash_cs_n),
        .flash_sck    (flash_sck),
        .flash_mosi   (flash_mosi),
        .flash_miso   (flash_miso)
    );

    // same fill rule as the flash model
    function automatic iosys_pkg::byte_t expected_flash_byte(input logic [23:0] a);
        return (a[7:0] ^ a[23:16]) + {a[12:8], a[15:13]} + 8'h3c;
    endfunction

    // four bytes of 2 on and 2 off
    function automatic logic rom_slot_valid(input int k);
        return k >= 1 && k <= 16 && (k - 1) % 4 < 2;
    endfunction

    function automatic iosys_pkg::byte_t rom_slot_byte(input iosys_pkg::word_t w, input int k);
        return w[8 * ((k - 1) / 4) +: 8];
    endfunction

    task automatic log_error(input string msg);
        errors = errors + 1;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests_run = tests_run + 1;
        if (errors == errs_at_start) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed", name);
        end
    endtask

    // one cpu bus transfer with valid held until ready
    task automatic bus_xfer(input iosys_pkg::word_t addr, input iosys_pkg::word_t wdata,
                            input iosys_pkg::strb_t wstrb, output iosys_pkg::word_t rdata);
        @(negedge clk);
        cpu_valid = 1'b1;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_wstrb = wstrb;
        do @(posedge clk); while (!cpu_ready);
        rdata = cpu_rdata;
        @(negedge clk);
        cpu_valid = 1'b0;
        cpu_wstrb = '0;
    endtask

    // ram responder where writes land at once and cpu accesses get a random ready delay
    always @(posedge clk) begin
        int unsigned      wa;
        iosys_pkg::word_t w;
        wa = ram_addr[22:2];
        w  = mem.exists(wa) ? mem[wa] : '0;
        if (ram_valid && |ram_wstrb) begin
            for (int l = 0; l < 4; l++)
                if (ram_wstrb[l])
                    w[8*l +: 8] = ram_wdata[8*l +: 8];
            mem[wa] = w;
        end
        ready_next = 1'b0;
        if (ram_valid && cpu_resetn && !ram_ready) begin
            if (delay_left < 0)
                delay_left = int'($urandom % 4);
            if (delay_left == 0) begin
                ready_next = 1'b1;
                rdata_next = w;
                delay_left = -1;
            end else begin
                delay_left = delay_left - 1;
            end
        end
    end

    always @(negedge clk) begin
        ram_ready <= ready_next;
        ram_rdata <= rdata_next;
    end

    assign rom_wr_seen = cpu_valid && cpu_ready && cpu_addr == iosys_pkg::reg_romdat_addr
                         && |cpu_wstrb;

    always @(posedge clk) begin
        if (!resetn) begin
            load_cnt    <= 0;
            rom_k       <= 0;
            overlay_exp <= 1'b1;
        end else begin
            if (ram_valid && !cpu_resetn)
                load_cnt <= load_cnt + 1;
            if (rom_wr_seen) begin
                rom_word <= cpu_wdata;
                rom_k    <= 1;
            end else if (rom_k != 0 && rom_k < 17) begin
                rom_k <= rom_k + 1;
            end
            if (cpu_valid && cpu_ready && cpu_addr == iosys_pkg::reg_char_addr
                && cpu_wstrb[0]) begin
                if (cpu_wdata[25:24] == 2'd1)
                    overlay_exp <= 1'b1;
                else if (cpu_wdata[25:24] == 2'd2)
                    overlay_exp <= 1'b0;
            end
        end
    end

    a_load_write: assert property (@(posedge clk) disable iff (!resetn)
        ram_valid && !cpu_resetn |-> load_cnt < iosys_pkg::fw_len
            && ram_addr == iosys_pkg::ram_addr_t'(load_cnt)
            && ram_wstrb == iosys_pkg::strb_t'(1 << (load_cnt % 4))
            && ram_wdata == {4{expected_flash_byte(iosys_pkg::flash_base + 24'(load_cnt))}})
        else log_error($sformatf("load write %0d: addr %h strb %b data %h", $sampled(load_cnt),
                       $sampled(ram_addr), $sampled(ram_wstrb), $sampled(ram_wdata)));

    // cpu leaves reset only after every byte is in and the flash is deselected
    a_release: assert property (@(posedge clk) disable iff (!resetn)
        cpu_resetn |-> load_cnt == iosys_pkg::fw_len && flash_cs_n)
        else log_error($sformatf("cpu released after %0d load writes", $sampled(load_cnt)));

    a_reg_ready: assert property (@(posedge clk) disable iff (!resetn)
        cpu_valid && cpu_addr[31:23] != '0 |-> cpu_ready)
        else log_error("register access without same cycle ready");

    a_id_read: assert property (@(posedge clk) disable iff (!resetn)
        cpu_valid && cpu_addr == iosys_pkg::reg_id_addr |-> cpu_rdata == 32'(iosys_pkg::core_id))
        else log_error($sformatf("id register read %h", $sampled(cpu_rdata)));

    a_joy_read: assert property (@(posedge clk) disable iff (!resetn)
        cpu_valid && cpu_addr == iosys_pkg::reg_joy_addr
            |-> cpu_rdata[27:16] == joy2 && cpu_rdata[11:0] == joy1
                && cpu_rdata[31:28] == '0 && cpu_rdata[15:12] == '0)
        else log_error($sformatf("joystick register read %h", $sampled(cpu_rdata)));

    a_unmapped_read: assert property (@(posedge clk) disable iff (!resetn)
        cpu_valid && cpu_addr == unmapped_addr |-> cpu_rdata == '0)
        else log_error($sformatf("unmapped address read %h", $sampled(cpu_rdata)));

    a_rom_valid: assert property (@(posedge clk) disable iff (!resetn)
        rom_do_valid == rom_slot_valid(rom_k))
        else log_error($sformatf("rom_do_valid %b at slot %0d", $sampled(rom_do_valid),
                       $sampled(rom_k)));

    a_rom_byte: assert property (@(posedge clk) disable iff (!resetn)
        rom_do_valid && rom_slot_valid(rom_k) |-> rom_do == rom_slot_byte(rom_word, rom_k))
        else log_error($sformatf("rom byte %h at slot %0d", $sampled(rom_do), $sampled(rom_k)));

    a_romctl_on: assert property (@(posedge clk) disable iff (!resetn)
        cpu_valid && cpu_addr == iosys_pkg::reg_romctl_addr && cpu_wstrb[0]
            && cpu_wdata[7:0] == 8'd1 |=> rom_loading)
        else log_error("rom_loading not set by control write of 1");

    a_romctl_off: assert property (@(posedge clk) disable iff (!resetn)
        cpu_valid && cpu_addr == iosys_pkg::reg_romctl_addr && cpu_wstrb[0]
            && cpu_wdata[7:0] == 8'd0 |=> !rom_loading)
        else log_error("rom_loading not cleared by control write of 0");

    a_overlay: assert property (@(posedge clk) disable iff (!resetn)
        overlay == overlay_exp)
        else log_error($sformatf("overlay %b, expected %b", $sampled(overlay),
                       $sampled(overlay_exp)));

    a_ram_read: assert property (@(posedge clk) disable iff (!resetn)
        cpu_valid && cpu_ready && cpu_wstrb == '0 && cpu_addr == ram_chk_addr
            |-> cpu_rdata == ram_chk_word)
        else log_error($sformatf("ram read %h, expected %h", $sampled(cpu_rdata),
                       $sampled(ram_chk_word)));

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        iosys_pkg::word_t rd;
        iosys_pkg::word_t t0;
        iosys_pkg::word_t t1;
        int               start_errs;
        void'($urandom(24691));
        ram_busy  = 1'b1;
        cpu_valid = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        joy1      = 12'h0a5;
        joy2      = 12'hc3f;

        // sdram comes up a few cycles after reset
        wait (resetn === 1'b1);
        repeat (8) @(negedge clk);
        ram_busy = 1'b0;

        start_errs = errors;
        while (!cpu_resetn) @(negedge clk);
        end_test("firmware load", start_errs);

        start_errs = errors;
        bus_xfer(iosys_pkg::reg_id_addr, '0, '0, rd);
        bus_xfer(iosys_pkg::reg_joy_addr, '0, '0, rd);
        joy1 = 12'($urandom);
        joy2 = 12'($urandom);
        bus_xfer(iosys_pkg::reg_joy_addr, '0, '0, rd);
        bus_xfer(unmapped_addr, '0, '0, rd);
        end_test("register reads", start_errs);

        start_errs = errors;
        bus_xfer(iosys_pkg::reg_time_addr, '0, '0, t0);
        repeat (3 * iosys_pkg::ticks_per_ms) @(negedge clk);
        bus_xfer(iosys_pkg::reg_time_addr, '0, '0, t1);
        timer_step: assert (t1 - t0 >= 2 && t1 - t0 <= 4)
            else log_error($sformatf("timer moved by %0d over 3 ms", t1 - t0));
        end_test("timer", start_errs);

        start_errs = errors;
        bus_xfer(iosys_pkg::reg_romctl_addr, 32'd1, 4'hf, rd);
        bus_xfer(iosys_pkg::reg_romdat_addr, $urandom, 4'hf, rd);
        repeat (6) @(negedge clk);
        bus_xfer(iosys_pkg::reg_romdat_addr, $urandom, 4'hf, rd);   // restart mid word
        repeat (20) @(negedge clk);
        bus_xfer(iosys_pkg::reg_romctl_addr, 32'd0, 4'hf, rd);
        end_test("rom streaming", start_errs);

        start_errs = errors;
        bus_xfer(iosys_pkg::reg_char_addr, 32'h0200_0000, 4'h1, rd);
        bus_xfer(iosys_pkg::reg_char_addr, 32'h0100_0000, 4'h1, rd);
        for (int i = 0; i < 4; i++) begin
            ram_chk_addr = 32'h0000_1000 + 32'(4 * i);
            ram_chk_word = $urandom;
            bus_xfer(ram_chk_addr, ram_chk_word, 4'hf, rd);
            bus_xfer(ram_chk_addr, '0, '0, rd);
        end
        end_test("overlay and ram", start_errs);

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
logic/iosys_pkg.sv
logic/spi_flash_reader.sv
logic/firmware_loader.sv
logic/io_regs.sv
logic/rom_byte_streamer.sv
logic/iosys.sv
sim/clock_gen.sv
sim/flash_model.sv
sim/tb_iosys.sv
